/* files.f */
+incdir+.
z80_dec_pkg.sv
z80_cb_decode.sv
z80_ed_decode.sv
z80_instr_decode.sv
z80_byte_queue.sv
z80_decoder.sv
tb_z80_decoder.sv

/* Makefile */
# Verilator flow for the z80 decoder front end

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= tb_z80_decoder
RTL_TOP   ?= z80_decoder
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_z80_ref.svh */
//////////////////////////////////////////////////
// expected decode of a byte sequence, and the sample
// instructions drawn as stimulus; included in the testbench
//////////////////////////////////////////////////

// entry layout {fixed opcode bytes, length, bytes}; operands after fixed are random
localparam int n_samples = 36;
logic [39:0] sample_tab [0:n_samples-1] = '{
  40'h11_00000000, 40'h11_41000000, 40'h11_46000000, 40'h11_70000000,
  40'h11_76000000, 40'h11_86000000, 40'h11_80000000, 40'h11_c9000000,
  40'h11_c0000000, 40'h11_ff000000, 40'h11_04000000,
  40'h12_3e000000, 40'h12_36000000, 40'h12_c6000000, 40'h12_18000000,
  40'h12_10000000,
  40'h22_cb000000, 40'h22_cb060000, 40'h22_cb7e0000, 40'h22_cbc70000,
  40'h22_cb3e0000,
  40'h22_ed440000, 40'h22_ed4c0000, 40'h22_ed460000, 40'h22_ed5e0000,
  40'h22_ed450000, 40'h22_ed4d0000, 40'h22_edb00000, 40'h22_ed780000,
  40'h22_ed770000,
  40'h13_c3000000, 40'h13_cd000000, 40'h13_21000000, 40'h13_3a000000,
  40'h24_ed4b0000, 40'h24_ed730000  // ED 4-byte loads
};

// ID of a register row or its (HL) neighbour, rows are paired in the enum
function automatic z80_id_t row_id(input z80_id_t base, input int row, input logic [2:0] f);
  return z80_id_t'(8'(int'(base) + 2 * row + ((f == hl_field) ? 1 : 0)));
endfunction

function automatic void ref_decode(input byte_t b [0:3], input int n,
                                   output logic rdy, output z80_id_t id);
  byte_t op;
  byte_t op2;
  op  = b[0];
  op2 = b[1];
  id  = id_none;
  if (n == 1)
  begin
    if (op == 8'h00) id = id_nop;
    else if (op == 8'h76) id = id_halt;
    else if (op[7:6] == 2'b01 && op[5:3] == hl_field) id = id_ld_hl_r;
    else if (op[7:6] == 2'b01) id = (op[2:0] == hl_field) ? id_ld_r_hl : id_ld_r_r;
    else if (op[7:3] == 5'b10000) id = (op[2:0] == hl_field) ? id_add_a_hl : id_add_a_r;
    else if (op == 8'hc9) id = id_ret;
    else if (op[7:6] == 2'b11 && op[2:0] == 3'b000) id = id_ret_cc;
    else if (op[7:6] == 2'b11 && op[2:0] == 3'b111) id = id_rst_p;
    else if (op[7:6] == 2'b00 && op[2:0] == 3'b100)
      id = (op[5:3] == hl_field) ? id_inc_hl : id_inc_r;
  end
  else if (n == 2)
  begin
    if (op == pfx_cb && op2[7:6] == 2'b00) id = row_id(id_rlc_r, int'(op2[5:3]), op2[2:0]);
    else if (op == pfx_cb) id = row_id(id_bit_b_r, int'(op2[7:6]) - 1, op2[2:0]);
    else if (op == pfx_ed)
    begin
      if (op2 == 8'h4d) id = id_reti;
      else if (op2 == 8'hb0) id = id_ldir;
      else if (op2 == 8'h77 || op2 == 8'h7f) id = id_nop;  // undocumented
      else if (op2[7:6] == 2'b01)
      begin
        case (op2[2:0])
          3'b100:  id = id_neg;
          3'b101:  id = id_retn;
          3'b000:  id = id_in_r_c;
          3'b110:  id = (op2[4:3] == 2'b11) ? id_im2 : (op2[4:3] == 2'b10) ? id_im1 : id_im0;
          default: id = id_none;
        endcase
      end
    end
    else if (op[7:6] == 2'b00 && op[2:0] == 3'b110)
      id = (op[5:3] == hl_field) ? id_ld_hl_n : id_ld_r_n;
    else if (op == 8'hc6) id = id_add_a_n;
    else if (op == 8'h18) id = id_jr_e;
    else if (op == 8'h10) id = id_djnz_e;
  end
  else if (n == 3)
  begin
    if (op == 8'hc3) id = id_jp_nn;
    else if (op == 8'hcd) id = id_call_nn;
    else if (op == 8'h3a) id = id_ld_a_nn;
    else if (op[7:6] == 2'b00 && op[3:0] == 4'b0001) id = id_ld_dd_imm;
  end
  else if (n == 4 && op == pfx_ed && op2[7:6] == 2'b01 && op2[2:0] == 3'b011)
    id = op2[3] ? id_ld_dd_nn : id_ld_nn_dd;
  rdy = (id != id_none);
endfunction

/* tb_z80_decoder.sv */
//////////////////////////////////////////////////
// testbench for the z80 decoder front end; random
// stream, back-pressure, invalid prefixes and flush
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_z80_decoder;

  import z80_dec_pkg::*;

  localparam int period = 40;
  localparam int n_rand = 60;

  logic    CLK, rst, flush, I_wait, xlator_stall;
  byte_t   I_byte;
  logic    z80dec_stall, I_word_rdy, invalid_inst;
  word_t   I_word;
  z80_id_t z80_I_ID;
  int      seed = 32'hd237;
  int      errors, checks, n_invalid, exp_invalid, err_mark;
  logic [39:0] exp_q [$];  // {id, word} per instruction still due
  logic [39:0] exp_head;

  `include "tb_z80_ref.svh"

  z80_decoder dut (
    .CLK(CLK), .rst(rst), .flush(flush), .I_wait(I_wait), .I_byte(I_byte),
    .xlator_stall(xlator_stall), .z80dec_stall(z80dec_stall), .I_word(I_word),
    .I_word_rdy(I_word_rdy), .z80_I_ID(z80_I_ID), .invalid_inst(invalid_inst)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(period / 2) CLK = ~CLK;
  end

  // worst case about 4 cycles a byte, plus reset and the directed tests
  initial
  begin
    #((n_rand * 4 * 4 + 200) * period);
    $display("watchdog: run did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  // compare each handed-off instruction with the oldest expected one
  always @(posedge CLK)
  begin
    if (!rst && invalid_inst) n_invalid++;
    if (!rst && I_word_rdy && !xlator_stall)
    begin
      checks++;
      assert (exp_q.size() != 0) else
      begin
        $display("ready cycle with no instruction outstanding, word %h", I_word);
        errors++;
      end
      if (exp_q.size() != 0)
      begin
        exp_head = exp_q.pop_front();
        assert (z80_I_ID == exp_head[39:32]) else
        begin
          $display("Error z80_I_ID %h expected %h", z80_I_ID, exp_head[39:32]);
          errors++;
        end
        assert (I_word == exp_head[31:0]) else
        begin
          $display("Error I_word %h expected %h", I_word, exp_head[31:0]);
          errors++;
        end
      end
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    assert (got == want) else
    begin
      $display("Error %s %h expected %h", name, got, want);
      errors++;
    end
  endtask

  // pick a sample, fill its operand bytes at random
  task automatic make_instr(input int idx, output byte_t b [0:3], output int len);
    logic [39:0] ent;
    ent = sample_tab[idx];
    len = int'(ent[35:32]);
    for (int i = 0; i < 4; i++)
      b[i] = (i >= int'(ent[39:36]) && i < len) ? 8'($random(seed)) : ent[31 - 8 * i -: 8];
  endtask

  task automatic expect_instr(input byte_t b [0:3], input int len);
    logic    rdy;
    z80_id_t id;
    word_t   w;
    ref_decode(b, len, rdy, id);
    w = '0;
    for (int i = 0; i < len; i++)
      w[31 - 8 * i -: 8] = b[i];
    if (rdy) exp_q.push_back({id, w});
    else exp_invalid++;  // never completes, dropped at four bytes
  endtask

  // called at a falling edge, returns at the falling edge after the last byte
  task automatic feed(input byte_t b [0:3], input int first, input int len);
    int gap;
    for (int i = first; i < len; i++)
    begin
      gap = int'($unsigned($random(seed)) % 3);
      I_wait = 1'b1;
      repeat (gap) @(negedge CLK);
      I_byte = b[i];
      I_wait = 1'b0;
      while (z80dec_stall) @(negedge CLK);  // source holds its byte
      @(negedge CLK);  // taken at the rising edge just passed
      I_wait = 1'b1;
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge CLK);
    repeat (2) @(negedge CLK);
  endtask

  task automatic report(input string name);
    $display("test %s: %s", name, (errors == err_mark) ? "ok" : "FAILED");
    err_mark = errors;
  endtask

  initial
  begin
    byte_t   ba [0:3];
    byte_t   bb [0:3];
    int      la, lb;
    word_t   held_word;
    z80_id_t held_id;
    rst = 1'b1;
    flush = 1'b0;
    I_wait = 1'b1;
    I_byte = '0;
    xlator_stall = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    rst = 1'b0;

    check_val("I_word_rdy", 32'(I_word_rdy), 0);
    check_val("z80dec_stall", 32'(z80dec_stall), 0);
    check_val("invalid_inst", 32'(invalid_inst), 0);
    check_val("z80_I_ID", 32'(z80_I_ID), 32'(id_none));
    check_val("I_word", I_word, 0);
    report("reset");

    for (int n = 0; n < n_rand; n++)
    begin
      make_instr(int'($unsigned($random(seed)) % n_samples), ba, la);
      expect_instr(ba, la);
      feed(ba, 0, la);
    end
    drain();
    report("random stream");

    ////////////////////////////////////////////////// back-pressure
    xlator_stall = 1'b1;
    make_instr(34, ba, la);
    expect_instr(ba, la);
    feed(ba, 0, la);
    make_instr(17, bb, lb);
    expect_instr(bb, lb);
    I_byte = bb[0];
    I_wait = 1'b0;  // offered but must not be taken
    held_word = I_word;
    held_id = z80_I_ID;
    repeat (3)
    begin
      @(negedge CLK);
      check_val("I_word_rdy", 32'(I_word_rdy), 1);
      check_val("z80dec_stall", 32'(z80dec_stall), 1);
      check_val("I_word", I_word, held_word);
      check_val("z80_I_ID", 32'(z80_I_ID), 32'(held_id));
    end
    xlator_stall = 1'b0;
    @(posedge CLK);
    @(negedge CLK);
    I_wait = 1'b1;
    feed(bb, 1, lb);
    drain();
    report("back-pressure");

    ////////////////////////////////////////////////// DD and FD prefixes
    ba = '{pfx_dd, 8'h21, 8'h34, 8'h12};
    expect_instr(ba, 4);
    feed(ba, 0, 4);
    make_instr(31, bb, lb);
    expect_instr(bb, lb);
    feed(bb, 0, lb);
    ba = '{pfx_fd, 8'h7e, 8'h05, 8'h00};
    expect_instr(ba, 4);
    feed(ba, 0, 4);
    make_instr(5, bb, lb);
    expect_instr(bb, lb);
    feed(bb, 0, lb);
    drain();
    check_val("invalid count", n_invalid, exp_invalid);
    report("invalid prefix");

    ////////////////////////////////////////////////// flush mid instruction
    make_instr(30, ba, la);
    feed(ba, 0, 2);  // partial jp, never expected
    flush = 1'b1;
    @(negedge CLK);
    flush = 1'b0;
    make_instr(24, bb, lb);
    expect_instr(bb, lb);
    feed(bb, 0, lb);
    drain();
    check_val("invalid count", n_invalid, exp_invalid);
    report("flush");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* z80_decoder.sv */
//////////////////////////////////////////////////
// z80 decoder top: byte queue feeding the decoder,
// plus stall back to the source and the invalid pulse
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module z80_decoder (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 I_wait,
  input  z80_dec_pkg::byte_t   I_byte,
  input  logic                 xlator_stall,
  output logic                 z80dec_stall,
  output z80_dec_pkg::word_t   I_word,
  output logic                 I_word_rdy,
  output z80_dec_pkg::z80_id_t z80_I_ID,
  output logic                 invalid_inst
);

  import z80_dec_pkg::*;

  count_t num_bytes;  // bytes held in the queue

  z80_byte_queue u_queue (
    .CLK          (CLK),
    .rst          (rst),
    .flush        (flush),
    .I_wait       (I_wait),
    .I_byte       (I_byte),
    .I_word_rdy   (I_word_rdy),
    .xlator_stall (xlator_stall),
    .I_word       (I_word),
    .num_bytes    (num_bytes)
  );

  z80_instr_decode u_decode (
    .num_bytes  (num_bytes),
    .I_word     (I_word),
    .I_word_rdy (I_word_rdy),
    .z80_I_ID   (z80_I_ID)
  );

  // source must hold its byte while the translator is busy
  assign z80dec_stall = I_word_rdy & xlator_stall;

  // four bytes and still no match, queue drops them next edge
  assign invalid_inst = (num_bytes == max_bytes) & ~I_word_rdy;

endmodule

`default_nettype wire

/* z80_byte_queue.sv */
//////////////////////////////////////////////////
// packs z80 opcode bytes into one instruction word
// and counts them; the decoder reports when it is whole
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module z80_byte_queue (
  input  logic                CLK,
  input  logic                rst,
  input  logic                flush,
  input  logic                I_wait,
  input  z80_dec_pkg::byte_t  I_byte,
  input  logic                I_word_rdy,
  input  logic                xlator_stall,
  output z80_dec_pkg::word_t  I_word,
  output z80_dec_pkg::count_t num_bytes
);

  import z80_dec_pkg::*;

  logic hold;  // finished word waiting on the translator
  logic done;  // word leaves the queue at this edge
  logic take;  // byte consumed at this edge

  // translator back-pressure freezes count and word
  assign hold = I_word_rdy & xlator_stall;

  // complete word, or four bytes that never decoded
  assign done = I_word_rdy | (num_bytes == max_bytes);

  assign take = ~I_wait & ~hold;

  //////////////////////////////////////////////////
  // byte states: the count is the state
  //////////////////////////////////////////////////
  always_ff @(posedge CLK)
  begin
    if (rst || flush)
    begin
      num_bytes <= '0;
      I_word    <= '0;
    end
    else if (take)
    begin
      if (done || (num_bytes == '0))
      begin
        // first byte of a new word, older bytes cleared
        I_word    <= {I_byte, 24'h000000};
        num_bytes <= 3'd1;
      end
      else
      begin
        case (num_bytes)
          3'd1:    I_word[23:16] <= I_byte;
          3'd2:    I_word[15:8]  <= I_byte;
          default: I_word[7:0]   <= I_byte;  // count 3, last slot
        endcase
        num_bytes <= num_bytes + 3'd1;
      end
    end
    else if (done && !hold)
    begin
      num_bytes <= '0;  // word handed off or dropped, source idle
    end
  end

endmodule

`default_nettype wire

/* z80_instr_decode.sv */
//////////////////////////////////////////////////
// combinational decode of the collected bytes; the count
// picks the table, CB and ED rows come from their own tables
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module z80_instr_decode (
  input  z80_dec_pkg::count_t  num_bytes,
  input  z80_dec_pkg::word_t   I_word,
  output logic                 I_word_rdy,
  output z80_dec_pkg::z80_id_t z80_I_ID
);

  import z80_dec_pkg::*;

  byte_t      op0;    // first byte
  logic [2:0] dst;    // first byte [5:3]
  logic [2:0] src;    // first byte [2:0]
  logic       cb_hit;
  z80_id_t    cb_id;
  logic       ed_hit;
  z80_id_t    ed_id;
  z80_id_t    id;

  assign op0 = I_word[31:24];
  assign dst = I_word[29:27];
  assign src = I_word[26:24];

  z80_cb_decode u_cb (
    .opcode (I_word[23:16]),
    .hit    (cb_hit),
    .id     (cb_id)
  );

  z80_ed_decode u_ed (
    .I_word    (I_word),
    .four_byte (num_bytes == max_bytes),
    .hit       (ed_hit),
    .id        (ed_id)
  );

  always_comb
  begin
    id = id_none;
    case (num_bytes)
      //////////////////////////////////////////////////
      // 1 byte
      3'd1:
      begin
        casez (op0)
          8'h00: id = id_nop;
          8'b01??????:
          begin
            if ((dst == hl_field) && (src == hl_field))
              id = id_halt;  // would be LD (HL),(HL)
            else if (dst == hl_field)
              id = id_ld_hl_r;
            else
              id = hl_pick(src, id_ld_r_r, id_ld_r_hl);
          end
          8'h0a: id = id_ld_a_bc;
          8'h1a: id = id_ld_a_de;
          8'h02: id = id_ld_bc_a;
          8'h12: id = id_ld_de_a;
          8'hf9: id = id_ld_sp_hl;
          8'b11??0101: id = id_push_qq;
          8'b11??0001: id = id_pop_qq;
          8'heb: id = id_ex_de_hl;
          8'h08: id = id_ex_af_af;
          8'hd9: id = id_exx;
          8'he3: id = id_ex_sp_hl;
          8'b10000???: id = hl_pick(src, id_add_a_r, id_add_a_hl);
          8'b10001???: id = hl_pick(src, id_adc_a_r, id_adc_a_hl);
          8'b10010???: id = hl_pick(src, id_sub_r, id_sub_hl);
          8'b10011???: id = hl_pick(src, id_sbc_a_r, id_sbc_a_hl);
          8'b10100???: id = hl_pick(src, id_and_r, id_and_hl);
          8'b10101???: id = hl_pick(src, id_xor_r, id_xor_hl);
          8'b10110???: id = hl_pick(src, id_or_r, id_or_hl);
          8'b10111???: id = hl_pick(src, id_cp_r, id_cp_hl);
          8'b00???100: id = hl_pick(dst, id_inc_r, id_inc_hl);
          8'b00???101: id = hl_pick(dst, id_dec_r, id_dec_hl);
          8'h27: id = id_daa;
          8'h2f: id = id_cpl;
          8'h3f: id = id_ccf;
          8'h37: id = id_scf;
          8'hf3: id = id_di;
          8'hfb: id = id_ei;
          8'b00??1001: id = id_add_hl_ss;
          8'b00??0011: id = id_inc_ss;
          8'b00??1011: id = id_dec_ss;
          8'h07: id = id_rlca;
          8'h17: id = id_rla;
          8'h0f: id = id_rrca;
          8'h1f: id = id_rra;
          8'he9: id = id_jp_hl;
          8'hc9: id = id_ret;
          8'b11???000: id = id_ret_cc;
          8'b11???111: id = id_rst_p;
          default: id = id_none;  // longer instruction, keep collecting
        endcase
      end
      //////////////////////////////////////////////////
      // 2 bytes
      3'd2:
      begin
        casez (op0)
          8'b00???110: id = hl_pick(dst, id_ld_r_n, id_ld_hl_n);
          8'hc6: id = id_add_a_n;
          8'hce: id = id_adc_a_n;
          8'hd6: id = id_sub_n;
          8'hde: id = id_sbc_a_n;
          8'he6: id = id_and_n;
          8'hf6: id = id_or_n;
          8'hee: id = id_xor_n;
          8'hfe: id = id_cp_n;
          8'h18: id = id_jr_e;
          8'h38: id = id_jr_c_e;
          8'h30: id = id_jr_nc_e;
          8'h28: id = id_jr_z_e;
          8'h20: id = id_jr_nz_e;
          8'h10: id = id_djnz_e;
          8'hdb: id = id_in_a_n;
          8'hd3: id = id_out_n_a;
          pfx_cb: id = cb_hit ? cb_id : id_none;
          pfx_ed: id = ed_hit ? ed_id : id_none;
          default: id = id_none;  // DD and FD land here too
        endcase
      end
      //////////////////////////////////////////////////
      // 3 bytes
      3'd3:
      begin
        casez (op0)
          8'h3a: id = id_ld_a_nn;
          8'h32: id = id_ld_nn_a;
          8'b00??0001: id = id_ld_dd_imm;
          8'h2a: id = id_ld_hl_nn;
          8'h22: id = id_ld_nn_hl;
          8'hc3: id = id_jp_nn;
          8'b11???010: id = id_jp_cc_nn;
          8'hcd: id = id_call_nn;
          8'b11???100: id = id_call_cc_nn;
          default: id = id_none;
        endcase
      end
      // 4 bytes, only the ED loads complete here
      3'd4: id = ed_hit ? ed_id : id_none;
      default: id = id_none;
    endcase
    z80_I_ID   = id;
    I_word_rdy = (id != id_none);
  end

endmodule

`default_nettype wire

/* z80_ed_decode.sv */
//////////////////////////////////////////////////
// ED prefix table; four_byte selects the LD dd,(nn)
// and LD (nn),dd forms, else the 2-byte forms
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module z80_ed_decode (
  input  z80_dec_pkg::word_t   I_word,
  input  logic                 four_byte,
  output logic                 hit,
  output z80_dec_pkg::z80_id_t id
);

  import z80_dec_pkg::*;

  byte_t op;  // byte after the prefix

  assign op = I_word[23:16];

  always_comb
  begin
    id = id_none;
    if (I_word[31:24] == pfx_ed)
    begin
      if (four_byte)
      begin
        casez (op)
          8'b01??1011: id = id_ld_dd_nn;
          8'b01??0011: id = id_ld_nn_dd;
          default:     id = id_none;
        endcase
      end
      else
      begin
        casez (op)
          // 01xxx111 column, register moves and RLD/RRD
          8'h47: id = id_ld_i_a;
          8'h4f: id = id_ld_r_a;
          8'h57: id = id_ld_a_i;
          8'h5f: id = id_ld_a_r;
          8'h67: id = id_rrd;
          8'h6f: id = id_rld;
          8'b0111?111: id = id_nop;   // undocumented 77 and 7f
          // block transfer, compare, in, out
          8'ha0: id = id_ldi;
          8'hb0: id = id_ldir;
          8'ha8: id = id_ldd;
          8'hb8: id = id_lddr;
          8'ha1: id = id_cpi;
          8'hb1: id = id_cpir;
          8'ha9: id = id_cpd;
          8'hb9: id = id_cpdr;
          8'ha2: id = id_ini;
          8'hb2: id = id_inir;
          8'haa: id = id_ind;
          8'hba: id = id_indr;
          8'ha3: id = id_outi;
          8'hb3: id = id_otir;
          8'hab: id = id_outd;
          8'hbb: id = id_otdr;
          8'b01???100: id = id_neg;   // every alias of 44
          8'b01?0?110: id = id_im0;   // 46, 4e, 66, 6e
          8'b01?10110: id = id_im1;   // 56, 76
          8'b01?11110: id = id_im2;   // 5e, 7e
          8'h4d:       id = id_reti;  // must precede the RETN pattern
          8'b01???101: id = id_retn;  // 45 plus aliases
          8'b01??1010: id = id_adc_hl_ss;
          8'b01??0010: id = id_sbc_hl_ss;
          8'b01???000: id = id_in_r_c;
          8'b01???001: id = id_out_c_r;
          default:     id = id_none;  // undefined, or a 4-byte form not yet full
        endcase
      end
    end
    hit = (id != id_none);
  end

endmodule

`default_nettype wire

/* z80_cb_decode.sv */
//////////////////////////////////////////////////
// CB prefix table, rotate/shift and BIT/RES/SET rows
// looked up on the second byte of a 2-byte word
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module z80_cb_decode (
  input  z80_dec_pkg::byte_t   opcode,
  output logic                 hit,
  output z80_dec_pkg::z80_id_t id
);

  import z80_dec_pkg::*;

  always_comb
  begin
    id = id_none;
    case (opcode[7:6])
      2'b00:
      begin
        // rotate and shift rows by opcode[5:3]
        case (opcode[5:3])
          3'd0:    id = hl_pick(opcode[2:0], id_rlc_r, id_rlc_hl);
          3'd1:    id = hl_pick(opcode[2:0], id_rrc_r, id_rrc_hl);
          3'd2:    id = hl_pick(opcode[2:0], id_rl_r, id_rl_hl);
          3'd3:    id = hl_pick(opcode[2:0], id_rr_r, id_rr_hl);
          3'd4:    id = hl_pick(opcode[2:0], id_sla_r, id_sla_hl);
          3'd5:    id = hl_pick(opcode[2:0], id_sra_r, id_sra_hl);
          3'd6:    id = hl_pick(opcode[2:0], id_sll_r, id_sll_hl);  // undocumented
          default: id = hl_pick(opcode[2:0], id_srl_r, id_srl_hl);
        endcase
      end
      2'b01:   id = hl_pick(opcode[2:0], id_bit_b_r, id_bit_b_hl);
      2'b10:   id = hl_pick(opcode[2:0], id_res_b_r, id_res_b_hl);
      default: id = hl_pick(opcode[2:0], id_set_b_r, id_set_b_hl);
    endcase
    hit = (id != id_none);
  end

endmodule

`default_nettype wire

/* z80_dec_pkg.sv */
//////////////////////////////////////////////////
// shared types, prefix bytes and instruction IDs of
// the z80 front end; queue and decode tables import it
//////////////////////////////////////////////////
`default_nettype none

package z80_dec_pkg;

  typedef logic [7:0]  byte_t;   // opcode or operand byte
  typedef logic [31:0] word_t;   // first byte in [31:24], fourth in [7:0]
  typedef logic [2:0]  count_t;  // bytes collected, 0 to 4

  localparam count_t     max_bytes = 3'd4;    // longest z80 instruction
  localparam logic [2:0] hl_field  = 3'b110;  // register field for (HL)

  // prefix bytes
  localparam byte_t pfx_cb = 8'hcb;
  localparam byte_t pfx_ed = 8'hed;
  localparam byte_t pfx_dd = 8'hdd;  // IX group, not decoded
  localparam byte_t pfx_fd = 8'hfd;  // IY group, not decoded

  //////////////////////////////////////////////////
  // instruction IDs, numbered in table order
  //////////////////////////////////////////////////
  typedef enum logic [7:0] {
    id_none = 8'd0,
    // unprefixed, 1 byte
    id_nop, id_ld_r_r, id_ld_r_hl, id_ld_hl_r, id_halt,
    id_ld_a_bc, id_ld_a_de, id_ld_bc_a, id_ld_de_a, id_ld_sp_hl,
    id_push_qq, id_pop_qq, id_ex_de_hl, id_ex_af_af, id_exx, id_ex_sp_hl,
    id_add_a_r, id_add_a_hl, id_adc_a_r, id_adc_a_hl,
    id_sub_r, id_sub_hl, id_sbc_a_r, id_sbc_a_hl,
    id_and_r, id_and_hl, id_or_r, id_or_hl,
    id_xor_r, id_xor_hl, id_cp_r, id_cp_hl,
    id_inc_r, id_inc_hl, id_dec_r, id_dec_hl,
    id_daa, id_cpl, id_ccf, id_scf, id_di, id_ei,
    id_add_hl_ss, id_inc_ss, id_dec_ss,
    id_rlca, id_rla, id_rrca, id_rra,
    id_jp_hl, id_ret, id_ret_cc, id_rst_p,
    // unprefixed, 2 bytes
    id_ld_r_n, id_ld_hl_n,
    id_add_a_n, id_adc_a_n, id_sub_n, id_sbc_a_n,
    id_and_n, id_or_n, id_xor_n, id_cp_n,
    id_jr_e, id_jr_c_e, id_jr_nc_e, id_jr_z_e, id_jr_nz_e, id_djnz_e,
    id_in_a_n, id_out_n_a,
    // CB group
    id_rlc_r, id_rlc_hl, id_rrc_r, id_rrc_hl,
    id_rl_r, id_rl_hl, id_rr_r, id_rr_hl,
    id_sla_r, id_sla_hl, id_sra_r, id_sra_hl,
    id_sll_r, id_sll_hl, id_srl_r, id_srl_hl,
    id_bit_b_r, id_bit_b_hl, id_res_b_r, id_res_b_hl, id_set_b_r, id_set_b_hl,
    // ED group, 2 bytes
    id_ld_a_i, id_ld_a_r, id_ld_i_a, id_ld_r_a,
    id_ldi, id_ldir, id_ldd, id_lddr,
    id_cpi, id_cpir, id_cpd, id_cpdr,
    id_neg, id_im0, id_im1, id_im2,
    id_adc_hl_ss, id_sbc_hl_ss, id_rld, id_rrd, id_reti, id_retn,
    id_in_r_c, id_ini, id_inir, id_ind, id_indr,
    id_out_c_r, id_outi, id_otir, id_outd, id_otdr,
    // unprefixed, 3 bytes
    id_ld_a_nn, id_ld_nn_a, id_ld_dd_imm, id_ld_hl_nn, id_ld_nn_hl,
    id_jp_nn, id_jp_cc_nn, id_call_nn, id_call_cc_nn,
    // ED group, 4 bytes
    id_ld_dd_nn, id_ld_nn_dd
  } z80_id_t;

  // register form or (HL) form of one table row
  function automatic z80_id_t hl_pick(input logic [2:0] field, input z80_id_t reg_id,
                                      input z80_id_t mem_id);
    return (field == hl_field) ? mem_id : reg_id;
  endfunction

endpackage

`default_nettype wire
